// ==== stream_buffer_top.f ====
hdl/stream_pack_pkg.sv
hdl/chunk_if.sv
hdl/ingress_packer.sv
hdl/chunk_fifo.sv
hdl/chunk_unpacker.sv
hdl/stream_buffer_top.sv
tests/tb_clock_gen.sv
tests/tb_stream_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the stream buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f stream_buffer_top.f \
    --top-module tb_stream_buffer -o sim_tb_stream_buffer
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_stream_buffer)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// ==== tests/tb_stream_buffer.sv ====
// table-driven testbench for stream_buffer_top; run as the simulation top with the project file list
`timescale 1ns/1ps

module tb_stream_buffer;
    import stream_pack_pkg::*;

    logic                    clk;
    logic                    reset;
    logic                    enable;
    logic                    drain;
    logic                    in_valid;
    logic                    in_ready;
    logic [beat_width-1:0]   in_data;
    logic                    in_last;
    logic [length_width-1:0] in_length;
    logic                    out_valid;
    logic [beat_width-1:0]   out_data;
    logic                    out_last;
    logic [count_width-1:0]  beat_count;

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    // single packets, held burst, admission edges, enable low, final packet
    int row_beats [19] = '{1, 2, 3, 4, 5, 6, 1, 1, 1, 1, 1, 1, 1, 1, 2, 3, 2, 6, 4};
    int row_length [19] = '{8, 15, 24, 32, 40, 48, 8, 8, 8, 8, 8, 8, 8, 8, 88, 96, 80, 8, 32};
    bit row_enable [19] = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 1};
    // 1 = drain free, 0 = drain held low
    bit row_free [19] = '{1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1};
    bit row_admit [19] = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 0, 1, 0, 1};

    // model state
    logic [beat_width:0]     expected_q [$];
    logic [count_width-1:0]  count_model;
    int                      credits_model;
    bit                      prev_held;
    logic [31:0]             lfsr_state;
    int                      value_errors;
    int                      other_errors;
    int                      stall_count;
    int                      ready_timeout = 200;
    int                      drain_timeout = 400;
    // cycles of held drain before the burst is released
    int                      stall_limit = 12;

    tb_clock_gen i_clock (
        .clk   (clk),
        .reset (reset)
    );

    stream_buffer_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .drain      (drain),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .in_last    (in_last),
        .in_length  (in_length),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .beat_count (beat_count)
    );

    ////////////////////////////////////////
    // compare tasks and random data
    ////////////////////////////////////////

    task automatic compare_beat(input logic [beat_width-1:0] got,
                                input logic [beat_width-1:0] expected);
        if (got !== expected)
        begin
            value_errors++;
            $display("Fail out_data: got %h expected %h", got, expected);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            value_errors++;
            $display("Fail %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic compare_count(input logic [count_width-1:0] got,
                                 input logic [count_width-1:0] expected);
        if (got !== expected)
        begin
            value_errors++;
            $display("Fail beat_count: got %h expected %h", got, expected);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // one lfsr step per data bit
    task automatic random_beat(output logic [beat_width-1:0] beat);
        beat = '0;
        for (int i = 0; i < beat_width; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            beat = {beat[beat_width-2:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////
    // waits, all bounded
    ////////////////////////////////////////

    // sampled at the falling edge, inputs already settled
    task automatic wait_ready(output bit ok);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!in_ready && waited < ready_timeout)
        begin
            @(posedge clk);
            #1;
            waited++;
            // held burst stalled, let the fifo empty
            if (!drain && waited >= stall_limit)
            begin
                drain = 1'b1;
                stall_count++;
            end
            @(negedge clk);
        end
        ok = in_ready;
        if (!ok)
        begin
            other_errors++;
            $display("timeout: in_ready stayed low for %0d cycles", waited);
        end
    endtask

    task automatic drain_all();
        int waited;
        waited = 0;
        drain = 1'b1;
        while (expected_q.size() != 0 && waited < drain_timeout)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expected_q.size() != 0)
        begin
            other_errors++;
            $display("timeout: %0d expected beats never came out", expected_q.size());
        end
        // last credit lands one edge after its beat
        repeat (2)
        begin
            @(posedge clk);
            #1;
        end
        credits_model = credit_limit - 1;
    endtask

    ////////////////////////////////////////
    // one table row
    ////////////////////////////////////////

    task automatic run_row(input int row);
        bit                    admit_model;
        bit                    ok;
        logic [beat_width-1:0] beat;
        // a held row after a held row keeps the burst going
        if (row_free[row] || !prev_held)
        begin
            drain_all();
            drain = row_free[row];
        end
        prev_held = !row_free[row];
        admit_model = row_enable[row] &&
            (credits_model > int'(row_length[row] >> beat_bytes_log2));
        if (admit_model != row_admit[row])
        begin
            other_errors++;
            $display("table row %0d expects admit %0d but the credit rule gives %0d",
                row, row_admit[row], admit_model);
        end
        if (!row_enable[row])
        begin
            // valid high with enable low, nothing may transfer
            enable = 1'b0;
            in_valid = 1'b1;
            in_last = 1'b1;
            in_length = length_width'(row_length[row]);
            repeat (row_beats[row])
            begin
                random_beat(beat);
                in_data = beat;
                @(negedge clk);
                compare_flag("in_ready", in_ready, 1'b0);
                @(posedge clk);
                #1;
            end
        end
        else
        begin
            for (int b = 0; b < row_beats[row]; b++)
            begin
                random_beat(beat);
                in_valid = 1'b1;
                in_data = beat;
                in_last = (b == row_beats[row] - 1);
                // length only on the first beat
                in_length = (b == 0) ? length_width'(row_length[row]) : '0;
                wait_ready(ok);
                if (!ok)
                begin
                    in_valid = 1'b0;
                    return;
                end
                @(posedge clk);
                count_model++;
                if (admit_model)
                begin
                    expected_q.push_back({in_last, in_data});
                    credits_model--;
                end
                #1;
            end
        end
        in_valid = 1'b0;
        in_last = 1'b0;
        enable = 1'b1;
        compare_count(beat_count, count_model);
    endtask

    // output side, checked while out_valid is stable
    always @(negedge clk)
    begin : output_monitor
        logic [beat_width:0] expected;
        if (!reset && out_valid)
        begin
            if (expected_q.size() == 0)
            begin
                other_errors++;
                $display("unexpected output beat %h with no beat pending", out_data);
            end
            else
            begin
                expected = expected_q.pop_front();
                compare_beat(out_data, expected[beat_width-1:0]);
                compare_flag("out_last", out_last, expected[beat_width]);
            end
        end
    end

    initial
    begin : main_sequence
        int waited;
        enable = 1'b0;
        drain = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_last = 1'b0;
        in_length = '0;
        lfsr_state = 32'hc2af_5b12;
        count_model = '0;
        credits_model = credit_limit - 1;
        prev_held = 1'b0;
        value_errors = 0;
        other_errors = 0;
        stall_count = 0;
        waited = 0;
        while (reset && waited < 20)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (reset)
        begin
            other_errors++;
            $display("timeout: reset never went low");
        end
        // idle state right after reset
        @(negedge clk);
        compare_flag("out_valid", out_valid, 1'b0);
        compare_flag("in_ready", in_ready, 1'b0);
        compare_count(beat_count, '0);
        @(posedge clk);
        #1;
        enable = 1'b1;
        for (int row = 0; row < 19; row++)
        begin
            run_row(row);
        end
        drain_all();
        if (stall_count == 0)
        begin
            other_errors++;
            $display("the held burst never stalled the input");
        end
        $display("errors: %0d value mismatches, %0d timeouts or protocol faults",
            value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
// testbench clock and reset source; 100 ns clock, reset held high for the first four rising edges
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        // released on the edge that ends the fourth cycle
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

    // 50 ns half period
    always #50 clk = ~clk;

endmodule

// ==== hdl/stream_buffer_top.sv ====
// top of the ingress stream buffer; packer, chunk fifo and unpacker behind plain stream ports
`timescale 1ns/1ps

module stream_buffer_top (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     enable,
    input  logic                                     drain,
    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  logic [stream_pack_pkg::beat_width-1:0]   in_data,
    input  logic                                     in_last,
    input  logic [stream_pack_pkg::length_width-1:0] in_length,
    output logic                                     out_valid,
    output logic [stream_pack_pkg::beat_width-1:0]   out_data,
    output logic                                     out_last,
    output logic [stream_pack_pkg::count_width-1:0]  beat_count
);

    // credit loop from egress back to admission
    logic credit_return;

    // packer to fifo, fifo to unpacker
    chunk_if wr_chunks ();
    chunk_if rd_chunks ();

    ingress_packer i_packer (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .in_valid      (in_valid),
        .in_last       (in_last),
        .in_data       (in_data),
        .in_length     (in_length),
        .credit_return (credit_return),
        .in_ready      (in_ready),
        .beat_count    (beat_count),
        .chunks        (wr_chunks)
    );

    chunk_fifo i_fifo (
        .clk   (clk),
        .reset (reset),
        .wr    (wr_chunks),
        .rd    (rd_chunks)
    );

    chunk_unpacker i_unpacker (
        .clk           (clk),
        .reset         (reset),
        .drain         (drain),
        .chunks        (rd_chunks),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .out_data      (out_data),
        .credit_return (credit_return)
    );

endmodule

// ==== hdl/chunk_unpacker.sv ====
// egress stage; drains chunks while drain is high, rebuilds the original beats and returns credits
`timescale 1ns/1ps

module chunk_unpacker (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   drain,
    chunk_if.unpacker                              chunks,
    output logic                                   out_valid,
    output logic                                   out_last,
    output logic [stream_pack_pkg::beat_width-1:0] out_data,
    output logic                                   credit_return
);
    import stream_pack_pkg::*;

    // low part of the beat still being rebuilt
    logic [chunk_width-1:0] pending;
    logic [chunk_width-1:0] pending_next;
    logic [beat_width-1:0]  beat_next;
    logic                   beat_done;

    // pop whenever allowed, no further back-pressure
    assign chunks.pop = drain && !chunks.empty;

    // phase 0 only opens a beat
    assign beat_done = (chunks.phase != '0);

    ////////////////////////////////////////
    // beat reassembly
    ////////////////////////////////////////

    always_comb
    begin
        pending_next = pending;
        beat_next = {chunks.data[15:0], pending};
        case (chunks.phase)
            2'd0:
                // 48 low bits of a new beat
                pending_next = chunks.data;
            2'd1:
            begin
                beat_next = {chunks.data[15:0], pending[47:0]};
                pending_next = {16'b0, chunks.data[47:16]};
            end
            2'd2:
            begin
                beat_next = {chunks.data[31:0], pending[31:0]};
                pending_next = {32'b0, chunks.data[47:32]};
            end
            default:
                // phase 3 holds the top 48 bits
                beat_next = {chunks.data[47:0], pending[15:0]};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (chunks.pop)
        begin
            pending <= pending_next;
            if (beat_done)
            begin
                out_data <= beat_next;
            end
        end
    end

    // strobes one cycle after the pop
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
            out_last <= 1'b0;
            credit_return <= 1'b0;
        end
        else
        begin
            out_valid <= chunks.pop && beat_done;
            out_last <= chunks.pop && beat_done && chunks.last;
            // one credit back per rebuilt beat
            credit_return <= chunks.pop && beat_done;
        end
    end

endmodule

// ==== hdl/chunk_fifo.sv ====
// synchronous show-ahead chunk fifo between packer and unpacker, with empty and almost-full flags
`timescale 1ns/1ps

module chunk_fifo (
    input  logic     clk,
    input  logic     reset,
    chunk_if.fifo_wr wr,
    chunk_if.fifo_rd rd
);
    import stream_pack_pkg::*;

    // storage, one entry per chunk
    logic [chunk_width-1:0]     mem_data [fifo_depth];
    logic [phase_width-1:0]     mem_phase [fifo_depth];
    logic                       mem_last [fifo_depth];

    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    // one extra bit to hold a full count
    logic [fifo_addr_width:0]   fill;

    logic                       do_push;
    logic                       do_pop;

    // push to a full buffer is dropped
    assign do_push = wr.push && (fill != (fifo_addr_width + 1)'(fifo_depth));
    assign do_pop = rd.pop && !rd.empty;

    // flags straight from the fill count
    assign rd.empty = (fill == '0);
    assign wr.almost_full = (fill >= (fifo_addr_width + 1)'(almost_full_level));

    // head shown before the pop
    assign rd.data = mem_data[rd_ptr];
    assign rd.phase = mem_phase[rd_ptr];
    assign rd.last = mem_last[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem_data[wr_ptr] <= wr.data;
            mem_phase[wr_ptr] <= wr.phase;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    ////////////////////////////////////////
    // pointers and fill
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
        end
        else
        begin
            // depth is a power of two, pointers wrap by themselves
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

// ==== hdl/ingress_packer.sv ====
// ingress stage; admits or drops whole packets against free credits and packs beats into chunks
`timescale 1ns/1ps

module ingress_packer (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     enable,
    input  logic                                     in_valid,
    input  logic                                     in_last,
    input  logic [stream_pack_pkg::beat_width-1:0]   in_data,
    input  logic [stream_pack_pkg::length_width-1:0] in_length,
    input  logic                                     credit_return,
    output logic                                     in_ready,
    output logic [stream_pack_pkg::count_width-1:0]  beat_count,
    chunk_if.packer                                  chunks
);
    import stream_pack_pkg::*;

    // packet tracking
    logic                    packet_start;
    logic                    admit;
    logic [credit_width-1:0] free_credits;

    // packing state
    logic [phase_width-1:0]  phase;
    logic [beat_width-1:0]   prev_beat;
    logic                    prev_last;

    // per-cycle decisions
    logic                    accept;
    logic                    admit_now;
    logic                    write;
    logic                    flush;
    logic [length_width-1:0] length_beats;
    logic [beat_width-1:0]   new_beat;
    logic [chunk_width-1:0]  next_chunk;

    ////////////////////////////////////////
    // handshake and admission
    ////////////////////////////////////////

    always_comb
    begin
        // flush cycle: phase 3, or the chunk closing a packet that ended at phase 0 or 1
        flush = (phase == phase_width'(3)) || (prev_last && (phase != '0));
        // no input taken while a flush chunk is formed
        in_ready = enable && !chunks.almost_full && !flush;
        accept = in_valid && in_ready;

        // byte length to beats
        length_beats = in_length >> beat_bytes_log2;
        // strict compare, keeps one beat of slack
        admit_now = length_width'(free_credits) > length_beats;

        // first beat decides, later beats follow the stored flag
        write = accept && (packet_start ? admit_now : admit);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            packet_start <= 1'b1;
            admit <= 1'b0;
            beat_count <= '0;
        end
        else if (accept)
        begin
            // every handshaken beat counts, dropped or not
            beat_count <= beat_count + 1'b1;
            packet_start <= in_last;
            if (packet_start)
            begin
                admit <= admit_now;
            end
        end
    end

    // one credit per written beat, one back per returned beat
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_credits <= credit_width'(credit_limit - 1);
        end
        else if (write && !credit_return)
        begin
            free_credits <= free_credits - 1'b1;
        end
        else if (!write && credit_return)
        begin
            free_credits <= free_credits + 1'b1;
        end
    end

    ////////////////////////////////////////
    // three beats into four chunks
    ////////////////////////////////////////

    always_comb
    begin
        // flush chunks carry zeros in the new-beat part
        new_beat = write ? in_data : '0;
        case (phase)
            2'd0:
                next_chunk = new_beat[47:0];
            2'd1:
                next_chunk = {new_beat[31:0], prev_beat[63:48]};
            2'd2:
                next_chunk = {new_beat[15:0], prev_beat[63:32]};
            default:
                // rest of the stored beat, no input
                next_chunk = prev_beat[63:16];
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase <= '0;
            prev_last <= 1'b0;
            chunks.push <= 1'b0;
        end
        else
        begin
            // chunk goes out one cycle after its beat or flush
            chunks.push <= write || flush;
            if (write)
            begin
                phase <= phase + 1'b1;
                prev_last <= in_last;
            end
            else if (flush)
            begin
                // every packet restarts at phase 0
                phase <= '0;
            end
        end
    end

    // chunk payload register and leftover beat
    always_ff @(posedge clk)
    begin
        if (write || flush)
        begin
            chunks.data <= next_chunk;
            chunks.phase <= phase;
            // last rides on the chunk completing the final beat
            chunks.last <= flush && prev_last;
        end
        if (write)
        begin
            prev_beat <= in_data;
        end
    end

endmodule

// ==== hdl/chunk_if.sv ====
// one packed chunk stream between two blocks; packer/fifo_wr on the write side, fifo_rd/unpacker on the read side
`timescale 1ns/1ps

interface chunk_if;
    import stream_pack_pkg::*;

    // chunk payload and tags
    logic [chunk_width-1:0] data;
    logic [phase_width-1:0] phase;
    logic                   last;
    // write strobe and fill flag
    logic                   push;
    logic                   almost_full;
    // read strobe and fill flag
    logic                   pop;
    logic                   empty;

    // producer into the fifo
    modport packer (output data, output phase, output last, output push, input almost_full);
    modport fifo_wr (input data, input phase, input last, input push, output almost_full);

    // show-ahead head towards the consumer
    modport fifo_rd (output data, output phase, output last, output empty, input pop);
    modport unpacker (input data, input phase, input last, input empty, output pop);

endinterface

// ==== hdl/stream_pack_pkg.sv ====
// shared widths, depths and credit constants for the ingress stream buffer; import in module bodies
package stream_pack_pkg;

    ////////////////////////////////////////
    // stream geometry
    ////////////////////////////////////////

    // one input or output beat
    localparam int beat_width = 64;
    // one packed fifo chunk, three beats fill four chunks
    localparam int chunk_width = 48;
    // phase tag carried with every chunk
    localparam int phase_width = 2;
    // packet length in bytes, on the first beat
    localparam int length_width = 16;
    // bytes per beat as a shift
    localparam int beat_bytes_log2 = 3;

    ////////////////////////////////////////
    // chunk fifo
    ////////////////////////////////////////

    localparam int fifo_depth = 16;
    localparam int fifo_addr_width = 4;
    // leaves room for chunks still in the packer pipeline
    localparam int almost_full_level = 13;

    ////////////////////////////////////////
    // credits and counters
    ////////////////////////////////////////

    // buffer capacity in beats (12 beats = 16 chunks)
    localparam int credit_limit = 12;
    localparam int credit_width = 5;
    // handshaken input beat counter
    localparam int count_width = 32;

endpackage
